// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_openadc
FILELIST  = sources.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "PASS: all tests"

clean:
	rm -rf $(OBJDIR)

// ==== clkmon/extclk_monitor.sv ====
`timescale 1ns/1ps

module extclk_monitor (
   input  logic                  clk_usb,
   input  logic                  reset,
   input  logic                  dut_clk_i,
   input  logic                  gate_i,
   input  logic                  monitor_off_i,
   input  adc_pkg::freq_t        limit_i,
   output adc_pkg::extclk_stat_t stat_o
);

   logic           sync1_q;
   logic           sync2_q;
   logic           sync3_q;      // previous synchronized level
   logic           rise;
   adc_pkg::freq_t count_q;      // edges in the running window
   adc_pkg::freq_t freq_q;       // edges in the last closed window
   adc_pkg::freq_t count_win;
   adc_pkg::freq_t diff;
   logic           change_q;

   // two-flop synchronizer, then edge detect in clk_usb
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         sync1_q <= 1'b0;
         sync2_q <= 1'b0;
         sync3_q <= 1'b0;
      end else begin
         sync1_q <= dut_clk_i;
         sync2_q <= sync1_q;
         sync3_q <= sync2_q;
      end
   end

   assign rise = sync2_q & ~sync3_q;

   // an edge seen in the gate cycle still belongs to the closing window
   always_comb begin
      count_win = count_q + adc_pkg::freq_t'(rise);
      if (count_win > freq_q)
         diff = count_win - freq_q;
      else
         diff = freq_q - count_win;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         count_q <= '0;
         freq_q  <= '0;
      end else if (gate_i) begin
         count_q <= '0;
         freq_q  <= count_win;
      end else begin
         count_q <= count_win;
      end
   end

   // sticky until the monitor is switched off
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         change_q <= 1'b0;
      end else if (monitor_off_i) begin
         change_q <= 1'b0;
      end else if (gate_i && (freq_q != '0) && (diff > limit_i)) begin
         change_q <= 1'b1;
      end
   end

   assign stat_o.freq   = freq_q;
   assign stat_o.change = change_q;

endmodule

// ==== clkmon/heartbeat_leds.sv ====
`timescale 1ns/1ps
`include "adc_cfg.svh"

module heartbeat_leds #(
   parameter int pGATE_BITS = `ADC_GATE_BITS
)(
   input  logic                 clk_usb,
   input  logic                 reset,
   input  logic                 arm_i,
   input  adc_pkg::led_mode_t   led_mode_i,
   input  logic                 change_i,
   output logic                 gate_o,
   output logic                 flash_pattern_o,
   output logic                 led_armed_o,
   output logic                 led_capture_o
);

   // timer must reach the gate bit as well as both LED taps
   localparam int TIMER_W = (pGATE_BITS > `ADC_LED_BIT) ? pGATE_BITS : `ADC_LED_BIT + 1;

   logic [TIMER_W-1:0] timer_q;
   logic               gate_bit_q;   // gate bit delayed, for edge detect

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer_q    <= '0;
         gate_bit_q <= 1'b0;
         gate_o     <= 1'b0;
      end else begin
         timer_q    <= timer_q + 1'b1;
         gate_bit_q <= timer_q[pGATE_BITS-1];
         gate_o     <= timer_q[pGATE_BITS-1] & ~gate_bit_q;   // one cycle per window
      end
   end

   // slow blink, used to flag a clock change
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         flash_pattern_o <= 1'b0;
      end else begin
         flash_pattern_o <= ~timer_q[`ADC_FLASH_BIT];
      end
   end

   always_comb begin
      if (change_i) begin
         // a detected change wins over any selected mode
         led_armed_o   = flash_pattern_o;
         led_capture_o = flash_pattern_o;
      end else begin
         case (led_mode_i)
            adc_pkg::LED_HEARTBEAT: begin
               led_armed_o   = timer_q[`ADC_LED_BIT];
               led_capture_o = timer_q[`ADC_LED_BIT];
            end
            adc_pkg::LED_FLASH: begin
               led_armed_o   = flash_pattern_o;
               led_capture_o = flash_pattern_o;
            end
            adc_pkg::LED_OFF: begin
               led_armed_o   = 1'b0;
               led_capture_o = 1'b0;
            end
            default: begin      // status
               led_armed_o   = arm_i;
               led_capture_o = change_i;
            end
         endcase
      end
   end

endmodule

// ==== common/adc_cfg.svh ====
`ifndef ADC_CFG_SVH
`define ADC_CFG_SVH

// register bus widths
`define ADC_REG_ADDR_W     8
`define ADC_BYTECNT_W      7

// register map, one address per register
`define ADC_ADDR_GAIN      8'd0
`define ADC_ADDR_SETTINGS  8'd1
`define ADC_ADDR_STATUS    8'd2
`define ADC_ADDR_EXTLIMIT  8'd3   // 4 bytes, lsb at bytecnt 0
`define ADC_ADDR_EXTFREQ   8'd4   // 4 bytes, read only

// gate window is 2**ADC_GATE_BITS clk_usb cycles
`define ADC_GATE_BITS      8

// heartbeat timer taps, kept above the gate bit
`define ADC_FLASH_BIT      (`ADC_GATE_BITS)
`define ADC_LED_BIT        (`ADC_GATE_BITS + 1)

// status byte
`define ADC_STAT_ARM       0
`define ADC_STAT_CHANGE    1
`define ADC_STAT_MONOFF    2

// settings byte, led mode occupies two bits from ADC_SET_LED_LO
`define ADC_SET_ARM        0
`define ADC_SET_LED_LO     1
`define ADC_SET_MONOFF     3

`endif

// ==== common/adc_pkg.sv ====
`include "adc_cfg.svh"

package adc_pkg;

   typedef logic [`ADC_REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [`ADC_BYTECNT_W-1:0]  bytecnt_t;
   typedef logic [7:0]                 reg_byte_t;
   typedef logic [31:0]                freq_t;     // edges per gate window
   typedef logic [7:0]                 gain_t;

   typedef enum logic [1:0] {
      LED_STATUS    = 2'd0,
      LED_HEARTBEAT = 2'd1,
      LED_FLASH     = 2'd2,
      LED_OFF       = 2'd3
   } led_mode_t;

   typedef struct packed {
      reg_addr_t address;
      bytecnt_t  bytecnt;
      reg_byte_t datai;
      logic      read;
      logic      write;
   } reg_bus_t;

   typedef struct packed {
      logic      arm;
      led_mode_t led_mode;
      logic      monitor_off;
      gain_t     gain;
      freq_t     extclk_limit;
   } adc_ctrl_t;

   typedef struct packed {
      freq_t freq;
      logic  change;
   } extclk_stat_t;

endpackage

// ==== rtl/adc_regs.sv ====
`timescale 1ns/1ps
`include "adc_cfg.svh"

module adc_regs (
   input  logic                  clk_usb,
   input  logic                  reset,
   input  adc_pkg::reg_bus_t     bus_i,
   input  adc_pkg::extclk_stat_t stat_i,
   output adc_pkg::adc_ctrl_t    ctrl_o,
   output adc_pkg::reg_byte_t    datao_o
);

   adc_pkg::reg_byte_t settings_q;
   adc_pkg::gain_t     gain_q;
   adc_pkg::freq_t     limit_q;
   adc_pkg::reg_byte_t status;
   logic               lane_ok;      // bytecnt points inside a 4-byte register

   // picks one byte of a 32-bit value, zero past the top byte
   function automatic adc_pkg::reg_byte_t byte_lane(input adc_pkg::freq_t word,
                                                     input adc_pkg::bytecnt_t idx);
      adc_pkg::reg_byte_t result;
      result = '0;
      if (idx < adc_pkg::bytecnt_t'(4))
         result = word[{idx[1:0], 3'b000} +: 8];
      return result;
   endfunction

   assign lane_ok = (bus_i.bytecnt < adc_pkg::bytecnt_t'(4));

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         settings_q <= '0;
         gain_q     <= '0;
         limit_q    <= '0;
      end else if (bus_i.write) begin
         case (bus_i.address)
            `ADC_ADDR_SETTINGS: begin
               if (bus_i.bytecnt == '0)
                  settings_q <= bus_i.datai;
            end
            `ADC_ADDR_GAIN: begin
               if (bus_i.bytecnt == '0)
                  gain_q <= bus_i.datai;
            end
            `ADC_ADDR_EXTLIMIT: begin
               if (lane_ok)
                  limit_q[{bus_i.bytecnt[1:0], 3'b000} +: 8] <= bus_i.datai;
            end
            default: ;   // status and frequency are read only
         endcase
      end
   end

   always_comb begin
      status                   = '0;
      status[`ADC_STAT_ARM]    = settings_q[`ADC_SET_ARM];
      status[`ADC_STAT_CHANGE] = stat_i.change;
      status[`ADC_STAT_MONOFF] = settings_q[`ADC_SET_MONOFF];
   end

   // zero-latency read mux
   always_comb begin
      datao_o = '0;
      if (bus_i.read) begin
         case (bus_i.address)
            `ADC_ADDR_SETTINGS: datao_o = byte_lane(adc_pkg::freq_t'(settings_q),
                                                    bus_i.bytecnt);
            `ADC_ADDR_STATUS:   datao_o = byte_lane(adc_pkg::freq_t'(status), bus_i.bytecnt);
            `ADC_ADDR_GAIN:     datao_o = byte_lane(adc_pkg::freq_t'(gain_q), bus_i.bytecnt);
            `ADC_ADDR_EXTLIMIT: datao_o = byte_lane(limit_q, bus_i.bytecnt);
            `ADC_ADDR_EXTFREQ:  datao_o = byte_lane(stat_i.freq, bus_i.bytecnt);
            default:            datao_o = '0;
         endcase
      end
   end

   assign ctrl_o.arm          = settings_q[`ADC_SET_ARM];
   assign ctrl_o.led_mode     = adc_pkg::led_mode_t'(settings_q[`ADC_SET_LED_LO +: 2]);
   assign ctrl_o.monitor_off  = settings_q[`ADC_SET_MONOFF];
   assign ctrl_o.gain         = gain_q;
   assign ctrl_o.extclk_limit = limit_q;

endmodule

// ==== rtl/openadc_interface.sv ====
`timescale 1ns/1ps
`include "adc_cfg.svh"

module openadc_interface (
   input  logic                clk_usb,
   input  logic                reset,
   input  adc_pkg::reg_addr_t  reg_address_i,
   input  adc_pkg::bytecnt_t   reg_bytecnt_i,
   input  adc_pkg::reg_byte_t  reg_datai_i,
   input  logic                reg_read_i,
   input  logic                reg_write_i,
   input  logic                dut_clk_i,       // target clock, asynchronous
   output adc_pkg::reg_byte_t  reg_datao_o,
   output logic                led_armed_o,
   output logic                led_capture_o,
   output logic                amp_gain_o,
   output logic                flash_pattern_o
);

   adc_pkg::reg_bus_t     reg_bus;
   adc_pkg::adc_ctrl_t    ctrl;
   adc_pkg::extclk_stat_t ext_stat;
   logic                  gate;
   logic [8:0]            pwm_acc_q;   // msb is the carry out

   assign reg_bus = '{address: reg_address_i,
                      bytecnt: reg_bytecnt_i,
                      datai:   reg_datai_i,
                      read:    reg_read_i,
                      write:   reg_write_i};

   adc_regs i_regs (
      .clk_usb (clk_usb),
      .reset   (reset),
      .bus_i   (reg_bus),
      .stat_i  (ext_stat),
      .ctrl_o  (ctrl),
      .datao_o (reg_datao_o)
   );

   heartbeat_leds #(
      .pGATE_BITS (`ADC_GATE_BITS)
   ) i_heartbeat (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .arm_i           (ctrl.arm),
      .led_mode_i      (ctrl.led_mode),
      .change_i        (ext_stat.change),
      .gate_o          (gate),
      .flash_pattern_o (flash_pattern_o),
      .led_armed_o     (led_armed_o),
      .led_capture_o   (led_capture_o)
   );

   extclk_monitor i_extclk (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .dut_clk_i     (dut_clk_i),
      .gate_i        (gate),
      .monitor_off_i (ctrl.monitor_off),
      .limit_i       (ctrl.extclk_limit),
      .stat_o        (ext_stat)
   );

   // gain PWM, carry rate is gain/256
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc_q <= '0;
      else
         pwm_acc_q <= {1'b0, pwm_acc_q[7:0]} + {1'b0, ctrl.gain};
   end

   assign amp_gain_o = pwm_acc_q[8];

endmodule

// ==== sources.f ====
+incdir+common
common/adc_pkg.sv
clkmon/heartbeat_leds.sv
clkmon/extclk_monitor.sv
rtl/adc_regs.sv
rtl/openadc_interface.sv
test/openadc_assert.sv
test/tb_openadc.sv

// ==== test/openadc_assert.sv ====
`timescale 1ns/1ps

module openadc_assert (
   input logic                  clk_usb,
   input logic                  reset,
   input logic                  gate_i,
   input adc_pkg::adc_ctrl_t    ctrl_i,
   input adc_pkg::extclk_stat_t stat_i,
   input logic                  led_armed_i,
   input logic                  led_capture_i
);

   int failures = 0;   // read by the testbench at the end of the run

   // gate is a single-cycle strobe
   gate_single: assert property (@(posedge clk_usb) disable iff (reset)
      gate_i |=> !gate_i)
      else begin
         $error("gate pulse lasted two cycles");
         failures = failures + 1;
      end

   // the flag clears one edge after monitor_off rises and stays clear
   change_held_clear: assert property (@(posedge clk_usb) disable iff (reset)
      ctrl_i.monitor_off && $past(ctrl_i.monitor_off) |-> !stat_i.change)
      else begin
         $error("change flag set while the monitor is off");
         failures = failures + 1;
      end

   leds_dark: assert property (@(posedge clk_usb) disable iff (reset)
      (ctrl_i.led_mode == adc_pkg::LED_OFF) && !stat_i.change |-> !led_armed_i && !led_capture_i)
      else begin
         $error("an LED is lit in LED_OFF mode");
         failures = failures + 1;
      end

endmodule

bind openadc_interface openadc_assert i_assert (
   .clk_usb       (clk_usb),
   .reset         (reset),
   .gate_i        (gate),
   .ctrl_i        (ctrl),
   .stat_i        (ext_stat),
   .led_armed_i   (led_armed_o),
   .led_capture_i (led_capture_o)
);

// ==== test/tb_openadc.sv ====
`timescale 1ns/1ps
`include "adc_cfg.svh"

module tb_openadc;

   localparam int CLK_PERIOD_NS = 40;
   localparam int GATE_CYCLES   = 1 << `ADC_GATE_BITS;
   localparam int GATE_TIMEOUT  = 2 * GATE_CYCLES + 4;   // cycles
   localparam int FLASH_HALF    = 1 << `ADC_FLASH_BIT;   // flash pattern half period, cycles

   logic                  clk_usb;
   logic                  reset;
   adc_pkg::reg_addr_t    bus_addr;
   adc_pkg::bytecnt_t     bus_cnt;
   adc_pkg::reg_byte_t    bus_datai;
   logic                  bus_read;
   logic                  bus_write;
   logic                  dut_clk;
   adc_pkg::reg_byte_t    bus_datao;
   logic                  led_armed;
   logic                  led_capture;
   logic                  amp_gain;
   logic                  flash_pattern;

   integer seed;
   int     ext_half_ns = 4 * CLK_PERIOD_NS;   // external clock, 8 clk_usb cycles

   openadc_interface i_dut (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .reg_address_i   (bus_addr),
      .reg_bytecnt_i   (bus_cnt),
      .reg_datai_i     (bus_datai),
      .reg_read_i      (bus_read),
      .reg_write_i     (bus_write),
      .dut_clk_i       (dut_clk),
      .reg_datao_o     (bus_datao),
      .led_armed_o     (led_armed),
      .led_capture_o   (led_capture),
      .amp_gain_o      (amp_gain),
      .flash_pattern_o (flash_pattern)
   );

   initial begin
      clk_usb = 1'b0;
      forever #(CLK_PERIOD_NS / 2) clk_usb = ~clk_usb;
   end

   // edges land on clk_usb falling edges for both periods used
   initial begin
      dut_clk = 1'b0;
      forever begin
         #(ext_half_ns);
         dut_clk = ~dut_clk;
      end
   end

   task automatic stop_on_error();
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check(input string test_name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
         stop_on_error();
      end
   endtask

   function automatic adc_pkg::reg_byte_t settings_byte(input logic arm,
                                                        input adc_pkg::led_mode_t mode,
                                                        input logic monoff);
      adc_pkg::reg_byte_t value;
      value                       = '0;
      value[`ADC_SET_ARM]         = arm;
      value[`ADC_SET_LED_LO +: 2] = mode;
      value[`ADC_SET_MONOFF]      = monoff;
      return value;
   endfunction

   function automatic adc_pkg::reg_byte_t status_byte(input logic arm, input logic change,
                                                      input logic monoff);
      adc_pkg::reg_byte_t value;
      value                   = '0;
      value[`ADC_STAT_ARM]    = arm;
      value[`ADC_STAT_CHANGE] = change;
      value[`ADC_STAT_MONOFF] = monoff;
      return value;
   endfunction

   task automatic reg_write(input adc_pkg::reg_addr_t addr, input adc_pkg::bytecnt_t cnt,
                            input adc_pkg::reg_byte_t data);
      @(posedge clk_usb);
      #2;
      bus_addr  = addr;
      bus_cnt   = cnt;
      bus_datai = data;
      bus_write = 1'b1;
      @(posedge clk_usb);   // register loads here
      #2;
      bus_write = 1'b0;
   endtask

   task automatic reg_read(input adc_pkg::reg_addr_t addr, input adc_pkg::bytecnt_t cnt,
                           output adc_pkg::reg_byte_t data);
      @(posedge clk_usb);
      #2;
      bus_addr = addr;
      bus_cnt  = cnt;
      bus_read = 1'b1;
      @(negedge clk_usb);
      data = bus_datao;
      @(posedge clk_usb);
      #2;
      bus_read = 1'b0;
   endtask

   task automatic write32(input adc_pkg::reg_addr_t addr, input adc_pkg::freq_t value);
      for (int i = 0; i < 4; i++)
         reg_write(addr, adc_pkg::bytecnt_t'(i), value[i*8 +: 8]);
   endtask

   task automatic read32(input adc_pkg::reg_addr_t addr, output adc_pkg::freq_t value);
      adc_pkg::reg_byte_t data;
      value = '0;
      for (int i = 0; i < 4; i++) begin
         reg_read(addr, adc_pkg::bytecnt_t'(i), data);
         value[i*8 +: 8] = data;
      end
   endtask

   // a window closes on the gate pulse, the frequency loads on the next edge
   task automatic wait_gate(input string test_name);
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < GATE_TIMEOUT) begin
         @(negedge clk_usb);
         seen = i_dut.gate;
         cycles++;
      end
      if (!seen) begin
         $display("%s: no gate pulse within %0d cycles", test_name, GATE_TIMEOUT);
         stop_on_error();
      end
      @(posedge clk_usb);
   endtask

   task automatic reg_rw();
      adc_pkg::freq_t     value;
      adc_pkg::reg_byte_t data;
      write32(`ADC_ADDR_EXTLIMIT, 32'h1234_5678);
      reg_write(`ADC_ADDR_GAIN, '0, 8'h5a);
      reg_write(`ADC_ADDR_SETTINGS, '0, settings_byte(1'b1, adc_pkg::LED_HEARTBEAT, 1'b1));
      read32(`ADC_ADDR_EXTLIMIT, value);
      check("reg_rw limit", 32'h1234_5678, value);
      reg_read(`ADC_ADDR_GAIN, '0, data);
      check("reg_rw gain", 32'h5a, 32'(data));
      reg_read(`ADC_ADDR_SETTINGS, '0, data);
      check("reg_rw settings",
            32'(settings_byte(1'b1, adc_pkg::LED_HEARTBEAT, 1'b1)), 32'(data));
      reg_read(`ADC_ADDR_STATUS, '0, data);
      check("reg_rw status", 32'(status_byte(1'b1, 1'b0, 1'b1)), 32'(data));
      reg_read(8'h7f, '0, data);   // nothing mapped here
      check("reg_rw unknown", 32'h0, 32'(data));
      reg_write(`ADC_ADDR_SETTINGS, '0, 8'h00);
      reg_write(`ADC_ADDR_GAIN, '0, 8'h00);
   endtask

   task automatic pwm_gain();
      adc_pkg::gain_t gain;
      int             high_cycles;
      for (int n = 0; n < 3; n++) begin
         gain = adc_pkg::gain_t'($random(seed));
         reg_write(`ADC_ADDR_GAIN, '0, gain);
         @(posedge clk_usb);   // first sum with the new gain
         high_cycles = 0;
         for (int c = 0; c < 256; c++) begin
            @(negedge clk_usb);
            if (amp_gain)
               high_cycles++;
         end
         check("pwm_gain", 32'(gain), 32'(high_cycles));
      end
   endtask

   task automatic freq_measure();
      adc_pkg::freq_t freq;
      adc_pkg::freq_t nominal;
      adc_pkg::freq_t expected;
      ext_half_ns = 4 * CLK_PERIOD_NS;
      nominal     = adc_pkg::freq_t'(GATE_CYCLES / 8);
      wait_gate("freq_measure");
      wait_gate("freq_measure");
      read32(`ADC_ADDR_EXTFREQ, freq);
      // one edge either way is within the synchronizer's reach
      if (freq + 1 >= nominal && freq <= nominal + 1)
         expected = freq;
      else
         expected = nominal;
      check("freq_measure", expected, freq);
   endtask

   task automatic change_detect();
      adc_pkg::reg_byte_t status;
      int                 windows;
      write32(`ADC_ADDR_EXTLIMIT, 32'd4);
      reg_write(`ADC_ADDR_SETTINGS, '0, settings_byte(1'b0, adc_pkg::LED_STATUS, 1'b0));
      wait_gate("change_detect");
      wait_gate("change_detect");
      reg_read(`ADC_ADDR_STATUS, '0, status);
      check("change_detect settled", 32'(status_byte(1'b0, 1'b0, 1'b0)), 32'(status));
      ext_half_ns = 2 * CLK_PERIOD_NS;   // twice the frequency
      windows     = 0;
      status      = '0;
      while (!status[`ADC_STAT_CHANGE] && windows < 2) begin
         wait_gate("change_detect");
         reg_read(`ADC_ADDR_STATUS, '0, status);
         windows++;
      end
      check("change_detect flag", 32'(status_byte(1'b0, 1'b1, 1'b0)), 32'(status));
      @(negedge clk_usb);
      check("change_detect led_armed", 32'(flash_pattern), 32'(led_armed));
      check("change_detect led_capture", 32'(flash_pattern), 32'(led_capture));
      reg_write(`ADC_ADDR_SETTINGS, '0, settings_byte(1'b0, adc_pkg::LED_STATUS, 1'b1));
      reg_read(`ADC_ADDR_STATUS, '0, status);
      check("change_detect clear", 32'(status_byte(1'b0, 1'b0, 1'b1)), 32'(status));
   endtask

   task automatic led_modes();
      int flash_high;
      reg_write(`ADC_ADDR_SETTINGS, '0, settings_byte(1'b1, adc_pkg::LED_STATUS, 1'b1));
      @(negedge clk_usb);
      check("led_modes status armed", 32'h1, 32'(led_armed));
      check("led_modes status capture", 32'h0, 32'(led_capture));
      reg_write(`ADC_ADDR_SETTINGS, '0, settings_byte(1'b0, adc_pkg::LED_OFF, 1'b1));
      @(negedge clk_usb);
      check("led_modes off armed", 32'h0, 32'(led_armed));
      check("led_modes off capture", 32'h0, 32'(led_capture));
      reg_write(`ADC_ADDR_SETTINGS, '0, settings_byte(1'b0, adc_pkg::LED_FLASH, 1'b1));
      // one full flash period, so both LED levels are seen
      flash_high = 0;
      for (int c = 0; c < 2 * FLASH_HALF; c++) begin
         @(negedge clk_usb);
         check("led_modes flash armed", 32'(flash_pattern), 32'(led_armed));
         check("led_modes flash capture", 32'(flash_pattern), 32'(led_capture));
         if (flash_pattern)
            flash_high++;
      end
      check("led_modes flash duty", 32'(FLASH_HALF), 32'(flash_high));
   endtask

   initial begin
      seed        = 32'hb170ee72;
      reset       = 1'b1;
      bus_addr    = '0;
      bus_cnt     = '0;
      bus_datai   = '0;
      bus_read    = 1'b0;
      bus_write   = 1'b0;
      repeat (4) @(posedge clk_usb);
      #2;
      reset = 1'b0;

      reg_rw();
      pwm_gain();
      freq_measure();
      change_detect();
      led_modes();

      if (i_dut.i_assert.failures == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         stop_on_error();
      end
   end

endmodule
